//--- include/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// datapath and register file
`define DEC_XLEN       32
`define DEC_NREG       32
`define DEC_RADDR_W    5

// opcode field of the register format, bits 31:15
`define DEC_OPR_W      17
// opcode field of the immediate format, bits 31:22
`define DEC_OPI_W      10
`define DEC_SI12_W     12
`define DEC_SI20_W     20

// one-hot ALU opcode
`define DEC_ALU_OP_W   12

`endif

//--- design/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    // register format: op | rk | rj | rd
    typedef struct packed {
        logic [`DEC_OPR_W-1:0]   op;
        logic [`DEC_RADDR_W-1:0] rk;
        logic [`DEC_RADDR_W-1:0] rj;
        logic [`DEC_RADDR_W-1:0] rd;
    } inst_r_t;

    // immediate format: op | si12 | rj | rd
    typedef struct packed {
        logic [`DEC_OPI_W-1:0]   op;
        logic [`DEC_SI12_W-1:0]  si12;
        logic [`DEC_RADDR_W-1:0] rj;
        logic [`DEC_RADDR_W-1:0] rd;
    } inst_i_t;

    typedef union packed {
        inst_r_t rtype;
        inst_i_t itype;
    } inst_word_u;

    typedef struct packed {
        logic [`DEC_XLEN-1:0] pc;
        inst_word_u           inst;
    } fd_bus_t;

    typedef struct packed {
        logic                    we;
        logic [`DEC_RADDR_W-1:0] dest;
    } ex_fwd_t;

    typedef struct packed {
        logic                    we;
        logic [`DEC_RADDR_W-1:0] dest;
        logic [`DEC_XLEN-1:0]    data;
    } wb_fwd_t;

    typedef struct packed {
        logic [`DEC_ALU_OP_W-1:0] alu_op;
        logic                     src2_is_imm;
        logic [`DEC_XLEN-1:0]     imm;
        logic                     src_reg_is_rd;
        logic                     gr_we;
        logic [3:0]               mem_we;
        logic [3:0]               res_from_mem;
        logic [`DEC_RADDR_W-1:0]  dest;
        logic                     unknown_inst;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`DEC_XLEN-1:0]     pc;
        logic [`DEC_ALU_OP_W-1:0] alu_op;
        logic [`DEC_XLEN-1:0]     alu_src1;
        logic [`DEC_XLEN-1:0]     alu_src2;
        logic [`DEC_XLEN-1:0]     rkd_value;
        logic                     gr_we;
        logic [3:0]               mem_we;
        logic [`DEC_RADDR_W-1:0]  dest;
        logic [3:0]               res_from_mem;
        logic                     unknown_inst;
    } de_bus_t;

    // alu_op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    // byte masks for mem_we and res_from_mem
    localparam logic [3:0] MASK_W = 4'b1111;
    localparam logic [3:0] MASK_H = 4'b0011;
    localparam logic [3:0] MASK_B = 4'b0001;
    // zero-extending load
    localparam logic [3:0] LD_UNS = 4'b0100;

endpackage

//--- design/decode_stage_reg.sv
module decode_stage_reg (
    input  logic                clk,
    input  logic                rstn,
    input  logic                flush,
    input  logic                in_valid,
    input  decode_pkg::fd_bus_t in_bus,
    input  logic                ready_go,
    input  logic                exec_allowin,
    output logic                allowin,
    output logic                stage_valid,
    output decode_pkg::fd_bus_t stage_bus
);

    logic leaving;

    assign leaving = ready_go && exec_allowin;
    assign allowin = !stage_valid || leaving;

    // flush wins over a new item
    always_ff @(posedge clk) begin
        if (!rstn) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;
        end else if (allowin) begin
            stage_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            stage_bus <= in_bus;
        end
    end

    // a stalled item must not be overwritten
    property p_hold_while_stalled;
        @(posedge clk) disable iff (!rstn)
            stage_valid && !leaving |=> $stable(stage_bus);
    endproperty

    a_hold_while_stalled: assert property (p_hold_while_stalled)
        else $error("decode stage item changed while stalled");

endmodule

//--- design/inst_decoder.sv
`include "decode_cfg.svh"

module inst_decoder (
    input  decode_pkg::inst_word_u inst,
    output decode_pkg::dec_ctrl_t  ctrl
);

    import decode_pkg::*;

    logic [`DEC_OPR_W-1:0]    opr;
    logic [`DEC_OPI_W-1:0]    opi;
    logic [`DEC_SI20_W-1:0]   si20;
    logic [`DEC_XLEN-1:0]     imm;
    logic [`DEC_ALU_OP_W-1:0] alu_op;
    logic [3:0]               mem_we;
    logic [3:0]               res_from_mem;

    assign opr  = inst.rtype.op;
    assign opi  = inst.itype.op;
    // bits 24:5 of the word
    assign si20 = {inst.itype.op[2:0], inst.itype.si12, inst.itype.rj};

    // 3R group, op 31:15
    wire inst_add_w  = (opr == 17'h00020);
    wire inst_sub_w  = (opr == 17'h00022);
    wire inst_slt    = (opr == 17'h00024);
    wire inst_sltu   = (opr == 17'h00025);
    wire inst_nor    = (opr == 17'h00028);
    wire inst_and    = (opr == 17'h00029);
    wire inst_or     = (opr == 17'h0002a);
    wire inst_xor    = (opr == 17'h0002b);
    wire inst_sll_w  = (opr == 17'h0002e);
    wire inst_srl_w  = (opr == 17'h0002f);
    wire inst_sra_w  = (opr == 17'h00030);
    wire inst_slli_w = (opr == 17'h00081);
    wire inst_srli_w = (opr == 17'h00089);
    wire inst_srai_w = (opr == 17'h00091);

    // 2RI12 group, op 31:22
    wire inst_slti   = (opi == 10'h008);
    wire inst_sltui  = (opi == 10'h009);
    wire inst_addi_w = (opi == 10'h00a);
    wire inst_andi   = (opi == 10'h00d);
    wire inst_ori    = (opi == 10'h00e);
    wire inst_xori   = (opi == 10'h00f);
    wire inst_ld_b   = (opi == 10'h0a0);
    wire inst_ld_h   = (opi == 10'h0a1);
    wire inst_ld_w   = (opi == 10'h0a2);
    wire inst_st_b   = (opi == 10'h0a4);
    wire inst_st_h   = (opi == 10'h0a5);
    wire inst_st_w   = (opi == 10'h0a6);
    wire inst_ld_bu  = (opi == 10'h0a8);
    wire inst_ld_hu  = (opi == 10'h0a9);

    // only bits 31:25 fixed
    wire inst_lu12i_w = (opr[16:10] == 7'h0a);

    wire is_load   = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    wire is_store  = inst_st_b | inst_st_h | inst_st_w;
    wire need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    wire need_zext = inst_andi | inst_ori | inst_xori;
    wire need_si12 = inst_slti | inst_sltui | inst_addi_w | is_load | is_store;

    wire known = |{inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and,
                   inst_or, inst_xor, inst_sll_w, inst_srl_w, inst_sra_w, need_ui5,
                   need_si12, need_zext, inst_lu12i_w};

    always_comb begin
        alu_op          = '0;
        alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | is_load | is_store;
        alu_op[ALU_SUB]  = inst_sub_w;
        alu_op[ALU_SLT]  = inst_slt | inst_slti;
        alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        alu_op[ALU_AND]  = inst_and | inst_andi;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or | inst_ori;
        alu_op[ALU_XOR]  = inst_xor | inst_xori;
        alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        alu_op[ALU_LUI]  = inst_lu12i_w;
    end

    always_comb begin
        if (inst_lu12i_w) begin
            imm = {si20, 12'b0};
        end else if (need_zext) begin
            imm = {20'b0, inst.itype.si12};
        end else if (need_ui5) begin
            imm = {{27{inst.rtype.rk[4]}}, inst.rtype.rk};
        end else begin
            imm = {{20{inst.itype.si12[11]}}, inst.itype.si12};
        end
    end

    always_comb begin
        mem_we = inst_st_w ? MASK_W :
                 inst_st_h ? MASK_H :
                 inst_st_b ? MASK_B : 4'b0000;
        res_from_mem = inst_ld_w  ? MASK_W :
                       inst_ld_h  ? MASK_H :
                       inst_ld_b  ? MASK_B :
                       inst_ld_hu ? (MASK_H | LD_UNS) :
                       inst_ld_bu ? (MASK_B | LD_UNS) : 4'b0000;
    end

    always_comb begin
        ctrl.alu_op        = alu_op;
        ctrl.src2_is_imm   = need_ui5 | need_si12 | need_zext | inst_lu12i_w;
        ctrl.imm           = imm;
        // stores read their data from rd
        ctrl.src_reg_is_rd = is_store;
        ctrl.gr_we         = known & ~is_store;
        ctrl.mem_we        = mem_we;
        ctrl.res_from_mem  = res_from_mem;
        ctrl.dest          = inst.rtype.rd;
        ctrl.unknown_inst  = ~known;
    end

endmodule

//--- design/regfile.sv
`include "decode_cfg.svh"

module regfile (
    input  logic                    clk,
    input  logic [`DEC_RADDR_W-1:0] raddr1,
    input  logic [`DEC_RADDR_W-1:0] raddr2,
    input  decode_pkg::wb_fwd_t     wb,
    output logic [`DEC_XLEN-1:0]    rdata1,
    output logic [`DEC_XLEN-1:0]    rdata2
);

    logic [`DEC_XLEN-1:0] rf [`DEC_NREG];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wb.we && wb.dest != '0) begin
            rf[wb.dest] <= wb.data;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

//--- design/operand_bypass.sv
`include "decode_cfg.svh"

module operand_bypass (
    input  logic                    stage_valid,
    input  decode_pkg::inst_word_u  inst,
    input  logic [`DEC_XLEN-1:0]    pc,
    input  decode_pkg::dec_ctrl_t   ctrl,
    input  logic [`DEC_XLEN-1:0]    rdata1,
    input  logic [`DEC_XLEN-1:0]    rdata2,
    input  decode_pkg::ex_fwd_t     ex_fwd,
    input  decode_pkg::wb_fwd_t     mem_fwd,
    input  decode_pkg::wb_fwd_t     wb,
    output logic [`DEC_RADDR_W-1:0] raddr1,
    output logic [`DEC_RADDR_W-1:0] raddr2,
    output logic                    hazard,
    output logic [`DEC_XLEN-1:0]    alu_src1,
    output logic [`DEC_XLEN-1:0]    alu_src2,
    output logic [`DEC_XLEN-1:0]    rkd_value
);

    import decode_pkg::*;

    logic [`DEC_XLEN-1:0] rj_value;
    logic                 use1;
    logic                 use2;
    logic                 ex_hit1;
    logic                 ex_hit2;

    // memory stage is younger than write-back, so it wins
    function automatic logic [`DEC_XLEN-1:0] pick(
        input logic [`DEC_RADDR_W-1:0] addr,
        input logic [`DEC_XLEN-1:0]    rf_val,
        input wb_fwd_t                 m,
        input wb_fwd_t                 w
    );
        if (addr == '0) begin
            return '0;
        end else if (m.we && m.dest == addr) begin
            return m.data;
        end else if (w.we && w.dest == addr) begin
            return w.data;
        end
        return rf_val;
    endfunction

    assign raddr1 = inst.rtype.rj;
    assign raddr2 = ctrl.src_reg_is_rd ? inst.rtype.rd : inst.rtype.rk;

    assign rj_value  = pick(raddr1, rdata1, mem_fwd, wb);
    assign rkd_value = pick(raddr2, rdata2, mem_fwd, wb);

    // lu12i.w has no rj; immediate forms read no rk
    assign use1 = !ctrl.alu_op[ALU_LUI];
    assign use2 = !ctrl.src2_is_imm || ctrl.src_reg_is_rd;

    assign ex_hit1 = use1 && ex_fwd.we && ex_fwd.dest != '0 && ex_fwd.dest == raddr1;
    assign ex_hit2 = use2 && ex_fwd.we && ex_fwd.dest != '0 && ex_fwd.dest == raddr2;
    assign hazard  = stage_valid && (ex_hit1 || ex_hit2);

    assign alu_src1 = rj_value;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rkd_value;

    always_comb begin
        a_hazard_needs_valid: assert (!hazard || stage_valid)
            else $error("hazard raised on an empty decode stage");
        // fetch only hands over word-aligned pcs
        a_pc_aligned: assert (!stage_valid || pc[1:0] == 2'b00)
            else $error("misaligned pc in decode stage");
    end

endmodule

//--- design/decode_top.sv
`include "decode_cfg.svh"

module decode_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                flush,
    input  logic                in_valid,
    input  decode_pkg::fd_bus_t in_bus,
    input  logic                exec_allowin,
    input  decode_pkg::ex_fwd_t ex_fwd,
    input  decode_pkg::wb_fwd_t mem_fwd,
    input  decode_pkg::wb_fwd_t wb,
    output logic                allowin,
    output logic                out_valid,
    output decode_pkg::de_bus_t out_bus
);

    import decode_pkg::*;

    fd_bus_t                 stage_bus;
    dec_ctrl_t               ctrl;
    logic                    stage_valid;
    logic                    ready_go;
    logic                    hazard;
    logic [`DEC_RADDR_W-1:0] raddr1;
    logic [`DEC_RADDR_W-1:0] raddr2;
    logic [`DEC_XLEN-1:0]    rdata1;
    logic [`DEC_XLEN-1:0]    rdata2;
    logic [`DEC_XLEN-1:0]    alu_src1;
    logic [`DEC_XLEN-1:0]    alu_src2;
    logic [`DEC_XLEN-1:0]    rkd_value;

    assign ready_go  = stage_valid && !hazard;
    assign out_valid = ready_go;

    decode_stage_reg u_stage (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_bus       (in_bus),
        .ready_go     (ready_go),
        .exec_allowin (exec_allowin),
        .allowin      (allowin),
        .stage_valid  (stage_valid),
        .stage_bus    (stage_bus)
    );

    inst_decoder u_dec (
        .inst (stage_bus.inst),
        .ctrl (ctrl)
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wb     (wb),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_bypass u_byp (
        .stage_valid (stage_valid),
        .inst        (stage_bus.inst),
        .pc          (stage_bus.pc),
        .ctrl        (ctrl),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .wb          (wb),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .hazard      (hazard),
        .alu_src1    (alu_src1),
        .alu_src2    (alu_src2),
        .rkd_value   (rkd_value)
    );

    assign out_bus = '{
        pc:           stage_bus.pc,
        alu_op:       ctrl.alu_op,
        alu_src1:     alu_src1,
        alu_src2:     alu_src2,
        rkd_value:    rkd_value,
        gr_we:        ctrl.gr_we,
        mem_we:       ctrl.mem_we,
        dest:         ctrl.dest,
        res_from_mem: ctrl.res_from_mem,
        unknown_inst: ctrl.unknown_inst
    };

endmodule

//--- sim/tb_decode.sv
`include "decode_cfg.svh"

module tb_decode;

    timeunit 1ns;
    timeprecision 100ps;

    import decode_pkg::*;

    localparam int HALF = 50;
    // roughly 95 cycles of tests times a margin of four
    localparam int MAX_CYCLES = 4 * (5 + 31 + 29 + 30);

    logic    clk;
    logic    rstn;
    logic    flush;
    logic    in_valid;
    fd_bus_t in_bus;
    logic    exec_allowin;
    ex_fwd_t ex_fwd;
    wb_fwd_t mem_fwd;
    wb_fwd_t wb;
    logic    allowin;
    logic    out_valid;
    de_bus_t out_bus;

    logic [31:0] shadow [32];
    logic [31:0] pc_next;
    int          seed;
    int          errors;
    int          checks;
    int          cycles;

    decode_top dut (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_bus       (in_bus),
        .exec_allowin (exec_allowin),
        .ex_fwd       (ex_fwd),
        .mem_fwd      (mem_fwd),
        .wb           (wb),
        .allowin      (allowin),
        .out_valid    (out_valid),
        .out_bus      (out_bus)
    );

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: decode stage testbench still running after %0d cycles", cycles);
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rand5();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic logic [31:0] reg_value(input logic [4:0] a);
        return (a == 5'd0) ? 32'd0 : shadow[a];
    endfunction

    // expected bundle from the field layout and the operand rules
    function automatic de_bus_t expected_bus(input logic [31:0] word, input int alu_bit,
                                             input logic imm_form, input logic [31:0] imm,
                                             input logic [3:0] mem_we, input logic [3:0] res);
        de_bus_t exp;
        logic    store;
        store            = (mem_we != 4'b0000);
        exp.pc           = pc_next;
        exp.alu_op       = 12'b1 << alu_bit;
        exp.alu_src1     = reg_value(word[9:5]);
        exp.alu_src2     = imm_form ? imm : reg_value(word[14:10]);
        // stores read rd as the data operand
        exp.rkd_value    = store ? reg_value(word[4:0]) : reg_value(word[14:10]);
        exp.gr_we        = !store;
        exp.mem_we       = mem_we;
        exp.dest         = word[4:0];
        exp.res_from_mem = res;
        exp.unknown_inst = 1'b0;
        return exp;
    endfunction

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bus(input string what, input de_bus_t exp);
        checks++;
        assert (out_bus === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s out_bus %h, expected %h", $time, what, out_bus,
                     exp);
        end
    endtask

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        wb = '{we: 1'b1, dest: a, data: d};
        @(negedge clk);
        wb.we = 1'b0;
        if (a != 5'd0) begin
            shadow[a] = d;
        end
    endtask

    // returns at the falling edge after the word was accepted
    task automatic issue(input logic [31:0] word);
        in_valid     = 1'b1;
        in_bus.pc    = pc_next;
        in_bus.inst  = word;
        while (!allowin) begin
            @(negedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic check_decode(input string name, input logic [31:0] word, input int alu_bit,
                                input logic imm_form, input logic [31:0] imm,
                                input logic [3:0] mem_we, input logic [3:0] res);
        de_bus_t exp;
        exp = expected_bus(word, alu_bit, imm_form, imm, mem_we, res);
        issue(word);
        check_flag({name, " out_valid"}, out_valid, 1'b1);
        check_bus(name, exp);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic test_reset();
        rstn = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        check_flag("out_valid after reset", out_valid, 1'b0);
        check_flag("allowin after reset", allowin, 1'b1);
        for (int a = 1; a < 32; a++) begin
            write_reg(5'(a), rand_word());
        end
    endtask

    task automatic test_reg_ops();
        logic [16:0] ops [11];
        int          bits [11];
        ops  = '{17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029,
                 17'h0002a, 17'h0002b, 17'h0002e, 17'h0002f, 17'h00030};
        bits = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND,
                 ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
        for (int i = 0; i < 11; i++) begin
            check_decode($sformatf("3r op %h", ops[i]), {ops[i], rand5(), rand5(), rand5()},
                         bits[i], 1'b0, 32'd0, 4'b0000, 4'b0000);
        end
    endtask

    task automatic test_imm_ops();
        logic [16:0] sh_ops [3];
        int          sh_bits [3];
        logic [9:0]  ops [6];
        int          bits [6];
        logic [4:0]  ui5;
        logic [11:0] si12;
        logic [19:0] si20;
        logic [4:0]  rd;
        sh_ops  = '{17'h00081, 17'h00089, 17'h00091};
        sh_bits = '{ALU_SLL, ALU_SRL, ALU_SRA};
        ops     = '{10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f};
        bits    = '{ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR};
        for (int i = 0; i < 3; i++) begin
            ui5 = rand5();
            check_decode($sformatf("shift op %h", sh_ops[i]), {sh_ops[i], ui5, rand5(), rand5()},
                         sh_bits[i], 1'b1, {{27{ui5[4]}}, ui5}, 4'b0000, 4'b0000);
        end
        for (int i = 0; i < 6; i++) begin
            si12 = 12'(rand_word());
            // andi, ori and xori zero-extend
            check_decode($sformatf("imm op %h", ops[i]), {ops[i], si12, rand5(), rand5()},
                         bits[i], 1'b1,
                         (i >= 3) ? {20'b0, si12} : {{20{si12[11]}}, si12}, 4'b0000, 4'b0000);
        end
        si20 = 20'(rand_word());
        rd   = rand5();
        check_decode("lu12i.w", {7'b0001010, si20, rd}, ALU_LUI, 1'b1, {si20, 12'b0},
                     4'b0000, 4'b0000);
    endtask

    task automatic test_mem_ops();
        logic [9:0]  ops [8];
        logic [3:0]  we [8];
        logic [3:0]  res [8];
        logic [11:0] si12;
        ops = '{10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9, 10'h0a4, 10'h0a5, 10'h0a6};
        we  = '{4'b0000, 4'b0000, 4'b0000, 4'b0000, 4'b0000, 4'b0001, 4'b0011, 4'b1111};
        res = '{4'b0001, 4'b0011, 4'b1111, 4'b0101, 4'b0111, 4'b0000, 4'b0000, 4'b0000};
        for (int i = 0; i < 8; i++) begin
            si12 = 12'(rand_word());
            check_decode($sformatf("mem op %h", ops[i]), {ops[i], si12, rand5(), rand5()},
                         ALU_ADD, 1'b1, {{20{si12[11]}}, si12}, we[i], res[i]);
        end
    endtask

    task automatic test_bypass();
        logic [31:0] d_mem;
        logic [31:0] d_wb;
        d_mem = rand_word();
        d_wb  = rand_word();
        // add.w r3, r7, r9
        issue({17'h00020, 5'd9, 5'd7, 5'd3});
        exec_allowin = 1'b0;
        mem_fwd = '{we: 1'b1, dest: 5'd7, data: d_mem};
        wb      = '{we: 1'b1, dest: 5'd7, data: d_wb};
        #(HALF / 2);
        check_word("rj with mem and wb hits", out_bus.alu_src1, d_mem);
        check_word("rk from register file", out_bus.alu_src2, reg_value(5'd9));
        @(negedge clk);
        shadow[7] = d_wb;
        mem_fwd.we = 1'b0;
        d_wb = rand_word();
        wb   = '{we: 1'b1, dest: 5'd9, data: d_wb};
        #(HALF / 2);
        check_word("rk with wb hit", out_bus.alu_src2, d_wb);
        check_word("rj after wb write", out_bus.alu_src1, reg_value(5'd7));
        @(negedge clk);
        shadow[9] = d_wb;
        wb.we = 1'b0;
        exec_allowin = 1'b1;
        pc_next = pc_next + 32'd4;
        // forwarding aimed at r0 must not leak through
        mem_fwd = '{we: 1'b1, dest: 5'd0, data: rand_word()};
        wb      = '{we: 1'b1, dest: 5'd0, data: rand_word()};
        issue({17'h00020, 5'd0, 5'd0, 5'd4});
        check_word("r0 as rj", out_bus.alu_src1, 32'd0);
        check_word("r0 as rk", out_bus.alu_src2, 32'd0);
        mem_fwd.we = 1'b0;
        wb.we = 1'b0;
        pc_next = pc_next + 32'd4;
    endtask

    task automatic test_hazard();
        logic [31:0] word;
        de_bus_t     exp;
        // and r5, r12, r13
        word = {17'h00029, 5'd13, 5'd12, 5'd5};
        exp  = expected_bus(word, ALU_AND, 1'b0, 32'd0, 4'b0000, 4'b0000);
        issue(word);
        ex_fwd = '{we: 1'b1, dest: 5'd12};
        repeat (2) begin
            @(negedge clk);
            check_flag("out_valid under hazard", out_valid, 1'b0);
            check_flag("allowin under hazard", allowin, 1'b0);
        end
        ex_fwd.we = 1'b0;
        #(HALF / 2);
        check_flag("out_valid after hazard", out_valid, 1'b1);
        check_flag("allowin after hazard", allowin, 1'b1);
        check_bus("released item", exp);
        @(negedge clk);
        check_flag("stage empty after release", out_valid, 1'b0);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic test_stall_flush();
        logic [31:0] word;
        de_bus_t     exp;
        word = {17'h0002b, rand5(), rand5(), rand5()};
        exp  = expected_bus(word, ALU_XOR, 1'b0, 32'd0, 4'b0000, 4'b0000);
        issue(word);
        exec_allowin = 1'b0;
        check_bus("xor under back-pressure", exp);
        // a younger item waits upstream and must stay out
        in_valid    = 1'b1;
        in_bus.pc   = pc_next + 32'd4;
        in_bus.inst = {17'h00020, rand5(), rand5(), rand5()};
        repeat (3) @(negedge clk);
        check_flag("out_valid while held", out_valid, 1'b1);
        check_flag("allowin while held", allowin, 1'b0);
        check_bus("xor still held", exp);
        in_valid = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_flag("out_valid after flush", out_valid, 1'b0);
        check_flag("allowin after flush", allowin, 1'b1);
        exec_allowin = 1'b1;
        pc_next = pc_next + 32'd4;
    endtask

    task automatic test_unknown();
        issue(32'hffff_ffff);
        check_flag("out_valid for unknown word", out_valid, 1'b1);
        check_flag("unknown_inst", out_bus.unknown_inst, 1'b1);
        check_flag("gr_we for unknown word", out_bus.gr_we, 1'b0);
        pc_next = pc_next + 32'd4;
    endtask

    initial begin
        seed         = 32'haf24_4ac8;
        errors       = 0;
        checks       = 0;
        pc_next      = 32'h1c00_0000;
        rstn         = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_bus       = '0;
        exec_allowin = 1'b1;
        ex_fwd       = '0;
        mem_fwd      = '0;
        wb           = '0;
        test_reset();
        test_reg_ops();
        test_imm_ops();
        test_mem_ops();
        test_bypass();
        test_hazard();
        test_stall_flush();
        test_unknown();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
design/decode_pkg.sv
design/decode_stage_reg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/decode_top.sv
sim/tb_decode.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_decode -f filelist.f \
    && ./obj_dir/Vtb_decode > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
